/* dsp_pkg.sv */
package dsp_pkg;

   // sample format of adc, dac and all routed signals
   localparam int SAMPLE_W = 14;
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   localparam int N_SLOTS = 4;  // gain slots in the array
   localparam int SEL_W   = 4;  // source code width

   // crossbar source codes, slots first
   typedef enum logic [SEL_W-1:0] {
      SRC_SLOT0 = 4'd0,
      SRC_SLOT1 = 4'd1,
      SRC_SLOT2 = 4'd2,
      SRC_SLOT3 = 4'd3,
      SRC_ASG1  = 4'd4,
      SRC_ASG2  = 4'd5,
      SRC_ADC1  = 4'd6,
      SRC_ADC2  = 4'd7,
      SRC_DAC1  = 4'd8,  // dac feedback
      SRC_DAC2  = 4'd9,
      SRC_NONE  = 4'd15  // routes zero
   } src_e;
   localparam int N_SOURCES = 10;

   // crossbar sinks, slot inputs first
   typedef enum logic [2:0] {
      SNK_SLOT0  = 3'd0,
      SNK_SLOT1  = 3'd1,
      SNK_SLOT2  = 3'd2,
      SNK_SLOT3  = 3'd3,
      SNK_SCOPE1 = 3'd4,
      SNK_SCOPE2 = 3'd5,
      SNK_PWM0   = 3'd6,
      SNK_PWM1   = 3'd7
   } sink_e;
   localparam int N_SINKS = 8;

   localparam int N_DIRECT = 6;  // 4 slots then asg1, asg2

   // bit 0 adds to dac a, bit 1 to dac b
   typedef enum logic [1:0] {
      OUT_OFF  = 2'd0,
      OUT_A    = 2'd1,
      OUT_B    = 2'd2,
      OUT_BOTH = 2'd3
   } out_sel_e;

   localparam int SUM_W     = SAMPLE_W + 4;  // headroom for the adder tree
   localparam int GAIN_W    = 16;
   localparam int GAIN_FRAC = 10;            // product >>> 10

endpackage

/* bus_pkg.sv */
package bus_pkg;

   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;

   // addr[15:0] is the offset, addr[19:16] picks the unit
   localparam int OFS_W   = 16;
   localparam int IDX_LSB = 16;
   localparam int IDX_W   = 4;

   // register offsets, local ones below the slot base
   typedef enum logic [OFS_W-1:0] {
      OFS_INSEL  = 16'h0000,  // source select of sink [idx]
      OFS_OUTSEL = 16'h0004,  // output enable of direct [idx]
      OFS_SAT    = 16'h0008,  // dac saturation flags, read only
      OFS_SYNC   = 16'h000C,  // slot run mask
      OFS_SIGNAL = 16'h0010,  // live value of source [idx]
      OFS_GAIN   = 16'h0020   // slot gain
   } reg_ofs_e;

   // everything from here up goes to the slot
   localparam logic [OFS_W-1:0] OFS_SLOT_BASE = 16'h0020;

endpackage

/* slot_bus_if.sv */
`timescale 1ns/1ps

// register access of one gain slot
// wen/ren are one-cycle pulses, ack follows one cycle later
interface slot_bus_if;

   logic                        wen;     // write pulse
   logic                        ren;     // read pulse
   logic [bus_pkg::OFS_W-1:0]   offset;  // local offset within the slot
   logic [bus_pkg::DATA_W-1:0]  wdata;
   logic [bus_pkg::DATA_W-1:0]  rdata;   // valid with ack
   logic                        ack;

   // register block side
   modport host (
      output wen, ren, offset, wdata,
      input  rdata, ack
   );

   // slot side
   modport slot (
      input  wen, ren, offset, wdata,
      output rdata, ack
   );

endinterface

/* dsp_regs.sv */
`timescale 1ns/1ps

module dsp_regs (
   input  logic                         clk_i,
   input  logic                         rstn_i,
   input  logic [bus_pkg::ADDR_W-1:0]   sys_addr_i,
   input  logic [bus_pkg::DATA_W-1:0]   sys_wdata_i,
   input  logic                         sys_wen_i,
   input  logic                         sys_ren_i,
   input  dsp_pkg::sample_t             sources_i [dsp_pkg::N_SOURCES],  // for readback
   input  logic [1:0]                   dac_sat_i,
   output logic [bus_pkg::DATA_W-1:0]   sys_rdata_o,
   output logic                         sys_ack_o,
   output dsp_pkg::src_e                sink_sel_o [dsp_pkg::N_SINKS],
   output dsp_pkg::out_sel_e            out_sel_o [dsp_pkg::N_DIRECT],
   output logic [dsp_pkg::N_SLOTS-1:0]  sync_o,
   slot_bus_if.host                     slot_bus [dsp_pkg::N_SLOTS]
);

   logic [bus_pkg::IDX_W-1:0]  idx;          // unit index
   logic [bus_pkg::OFS_W-1:0]  ofs;          // register offset
   logic                       req;          // any bus pulse
   logic                       fwd;          // access goes to a slot
   logic [bus_pkg::DATA_W-1:0] local_rdata;
   logic [dsp_pkg::N_SLOTS-1:0] slot_ack;
   logic [bus_pkg::DATA_W-1:0] slot_rdata [dsp_pkg::N_SLOTS];
   logic [bus_pkg::DATA_W-1:0] slot_rdata_sel;

   assign idx = sys_addr_i[bus_pkg::IDX_LSB +: bus_pkg::IDX_W];
   assign ofs = sys_addr_i[bus_pkg::OFS_W-1:0];
   assign req = sys_wen_i | sys_ren_i;
   assign fwd = (ofs >= bus_pkg::OFS_SLOT_BASE) && (int'(idx) < dsp_pkg::N_SLOTS);

   // slot access goes out combinationally, slot acks one cycle later
   for (genvar k = 0; k < dsp_pkg::N_SLOTS; k++) begin : g_fwd
      assign slot_bus[k].wen    = sys_wen_i & fwd & (int'(idx) == k);
      assign slot_bus[k].ren    = sys_ren_i & fwd & (int'(idx) == k);
      assign slot_bus[k].offset = ofs;
      assign slot_bus[k].wdata  = sys_wdata_i;
      assign slot_ack[k]        = slot_bus[k].ack;
      assign slot_rdata[k]      = slot_bus[k].rdata;
   end

   always_comb begin
      slot_rdata_sel = '0;
      for (int k = 0; k < dsp_pkg::N_SLOTS; k++) begin
         if (slot_ack[k]) slot_rdata_sel = slot_rdata[k];  // at most one acks
      end
   end

   // routing, enable and sync registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < dsp_pkg::N_SLOTS; k++) sink_sel_o[k] <= dsp_pkg::SRC_ADC1;
         sink_sel_o[dsp_pkg::SNK_SCOPE1] <= dsp_pkg::SRC_ADC1;
         sink_sel_o[dsp_pkg::SNK_SCOPE2] <= dsp_pkg::SRC_ADC2;
         sink_sel_o[dsp_pkg::SNK_PWM0]   <= dsp_pkg::SRC_NONE;  // pwm off
         sink_sel_o[dsp_pkg::SNK_PWM1]   <= dsp_pkg::SRC_NONE;
         for (int k = 0; k < dsp_pkg::N_DIRECT; k++) out_sel_o[k] <= dsp_pkg::OUT_OFF;
         sync_o <= '1;  // all slots running
      end else if (sys_wen_i) begin
         case (ofs)
            bus_pkg::OFS_INSEL: begin
               for (int k = 0; k < dsp_pkg::N_SINKS; k++) begin
                  if (int'(idx) == k)
                     sink_sel_o[k] <= dsp_pkg::src_e'(sys_wdata_i[dsp_pkg::SEL_W-1:0]);
               end
            end
            bus_pkg::OFS_OUTSEL: begin
               for (int k = 0; k < dsp_pkg::N_DIRECT; k++) begin
                  if (int'(idx) == k) out_sel_o[k] <= dsp_pkg::out_sel_e'(sys_wdata_i[1:0]);
               end
            end
            bus_pkg::OFS_SYNC: sync_o <= sys_wdata_i[dsp_pkg::N_SLOTS-1:0];
            default: ;  // read-only or slot region
         endcase
      end
   end

   // local read mux, unknown offsets and indices read 0
   always_comb begin
      local_rdata = '0;
      case (ofs)
         bus_pkg::OFS_INSEL: begin
            for (int k = 0; k < dsp_pkg::N_SINKS; k++) begin
               if (int'(idx) == k)
                  local_rdata = {{(bus_pkg::DATA_W-dsp_pkg::SEL_W){1'b0}}, sink_sel_o[k]};
            end
         end
         bus_pkg::OFS_OUTSEL: begin
            for (int k = 0; k < dsp_pkg::N_DIRECT; k++) begin
               if (int'(idx) == k) local_rdata = {{(bus_pkg::DATA_W-2){1'b0}}, out_sel_o[k]};
            end
         end
         bus_pkg::OFS_SAT:  local_rdata = {{(bus_pkg::DATA_W-2){1'b0}}, dac_sat_i};
         bus_pkg::OFS_SYNC: local_rdata = {{(bus_pkg::DATA_W-dsp_pkg::N_SLOTS){1'b0}}, sync_o};
         bus_pkg::OFS_SIGNAL: begin
            for (int k = 0; k < dsp_pkg::N_SOURCES; k++) begin
               if (int'(idx) == k)
                  local_rdata = {{(bus_pkg::DATA_W-dsp_pkg::SAMPLE_W){1'b0}}, sources_i[k]};
            end
         end
         default: local_rdata = '0;
      endcase
   end

   // local: ack 1 cycle after the pulse, slot: 1 cycle after slot ack
   always_ff @(posedge clk_i) begin
      if (!rstn_i) sys_ack_o <= 1'b0;
      else         sys_ack_o <= (req & ~fwd) | (|slot_ack);
   end

   always_ff @(posedge clk_i) begin
      if (req && !fwd)   sys_rdata_o <= local_rdata;
      else if (|slot_ack) sys_rdata_o <= slot_rdata_sel;
   end

   // every ack answers a pulse of one (local) or two (slot) cycles before
   a_ack_has_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_ack_o |-> ($past(req, 1) || $past(req, 2)));

endmodule

/* signal_router.sv */
`timescale 1ns/1ps

// crossbar, one mux per sink over all sources
module signal_router (
   input  dsp_pkg::sample_t sources_i  [dsp_pkg::N_SOURCES],
   input  dsp_pkg::src_e    sink_sel_i [dsp_pkg::N_SINKS],
   output dsp_pkg::sample_t sinks_o    [dsp_pkg::N_SINKS]
);

   // purely combinational, a sink follows its source in the same cycle
   always_comb begin
      for (int s = 0; s < dsp_pkg::N_SINKS; s++) begin
         sinks_o[s] = '0;  // none and unused codes give zero
         for (int k = 0; k < dsp_pkg::N_SOURCES; k++) begin
            if (int'(sink_sel_i[s]) == k) sinks_o[s] = sources_i[k];
         end
      end
   end

endmodule

/* gain_slot.sv */
`timescale 1ns/1ps

// programmable signed gain, two pipeline stages
module gain_slot (
   input  logic             clk_i,
   input  logic             rstn_i,
   input  logic             enable_i,  // low freezes the pipeline
   input  dsp_pkg::sample_t dat_i,
   output dsp_pkg::sample_t dat_o,
   slot_bus_if.slot         bus
);

   logic signed [dsp_pkg::GAIN_W-1:0]                  gain_q;
   logic signed [dsp_pkg::SAMPLE_W+dsp_pkg::GAIN_W-1:0] prod_q;   // stage 1
   logic signed [dsp_pkg::SAMPLE_W+dsp_pkg::GAIN_W-1:0] shifted;
   dsp_pkg::sample_t                                   sat_val;

   // gain register and slot bus, ack one cycle after the pulse
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         gain_q  <= '0;
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.wen | bus.ren;
         if (bus.wen && bus.offset == bus_pkg::OFS_GAIN)
            gain_q <= bus.wdata[dsp_pkg::GAIN_W-1:0];
      end
   end

   // other offsets read 0
   always_ff @(posedge clk_i) begin
      if (bus.offset == bus_pkg::OFS_GAIN)
         bus.rdata <= {{(bus_pkg::DATA_W-dsp_pkg::GAIN_W){1'b0}}, gain_q};
      else
         bus.rdata <= '0;
   end

   assign shifted = prod_q >>> dsp_pkg::GAIN_FRAC;  // arithmetic, keeps sign

   // clamp when the bits above the sample msb are not a sign extension
   always_comb begin
      if ((&shifted[dsp_pkg::SAMPLE_W+dsp_pkg::GAIN_W-1:dsp_pkg::SAMPLE_W-1]) ||
          (~|shifted[dsp_pkg::SAMPLE_W+dsp_pkg::GAIN_W-1:dsp_pkg::SAMPLE_W-1]))
         sat_val = shifted[dsp_pkg::SAMPLE_W-1:0];
      else if (shifted[dsp_pkg::SAMPLE_W+dsp_pkg::GAIN_W-1])
         sat_val = {1'b1, {(dsp_pkg::SAMPLE_W-1){1'b0}}};  // negative rail
      else
         sat_val = {1'b0, {(dsp_pkg::SAMPLE_W-1){1'b1}}};  // positive rail
   end

   // stage 1 multiply, stage 2 shift/saturate
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         prod_q <= '0;
         dat_o  <= '0;
      end else if (enable_i) begin
         prod_q <= dat_i * gain_q;  // signed 14x16
         dat_o  <= sat_val;
      end
   end

   // paused slot keeps its output
   a_freeze: assert property (@(posedge clk_i) disable iff (!rstn_i)
      $past(!enable_i) |-> $stable(dat_o));

endmodule

/* dac_summer.sv */
`timescale 1ns/1ps

// masked adder tree for both dacs, then clamp
// latency 4: pairs, quads, total, saturate
module dac_summer (
   input  logic              clk_i,
   input  logic              rstn_i,
   input  dsp_pkg::sample_t  direct_i  [dsp_pkg::N_DIRECT],
   input  dsp_pkg::out_sel_e out_sel_i [dsp_pkg::N_DIRECT],
   output dsp_pkg::sample_t  dac_a_o,
   output dsp_pkg::sample_t  dac_b_o,
   output logic [1:0]        sat_o     // [0] dac a, [1] dac b
);

   logic signed [dsp_pkg::SUM_W-1:0] leaf    [2][8];  // 8 leaves per channel
   logic signed [dsp_pkg::SUM_W-1:0] pair_q  [2][4];
   logic signed [dsp_pkg::SUM_W-1:0] quad_q  [2][2];
   logic signed [dsp_pkg::SUM_W-1:0] total_q [2];
   dsp_pkg::sample_t                 clamp   [2];
   logic [1:0]                       ovf;
   dsp_pkg::sample_t                 dac_q   [2];

   // sign-extend enabled contributors, unused leaves stay zero
   always_comb begin
      logic [1:0] en;
      en = '0;
      for (int ch = 0; ch < 2; ch++) begin
         for (int n = 0; n < 8; n++) leaf[ch][n] = '0;
      end
      for (int n = 0; n < dsp_pkg::N_DIRECT; n++) begin
         en = out_sel_i[n];  // bit per channel
         for (int ch = 0; ch < 2; ch++) begin
            if (en[ch])
               leaf[ch][n] = {{(dsp_pkg::SUM_W-dsp_pkg::SAMPLE_W){direct_i[n][dsp_pkg::SAMPLE_W-1]}},
                              direct_i[n]};
         end
      end
   end

   // clamp total to the sample range
   always_comb begin
      for (int ch = 0; ch < 2; ch++) begin
         ovf[ch] = !((&total_q[ch][dsp_pkg::SUM_W-1:dsp_pkg::SAMPLE_W-1]) ||
                     (~|total_q[ch][dsp_pkg::SUM_W-1:dsp_pkg::SAMPLE_W-1]));
         if (!ovf[ch])
            clamp[ch] = total_q[ch][dsp_pkg::SAMPLE_W-1:0];
         else if (total_q[ch][dsp_pkg::SUM_W-1])
            clamp[ch] = {1'b1, {(dsp_pkg::SAMPLE_W-1){1'b0}}};  // negative rail
         else
            clamp[ch] = {1'b0, {(dsp_pkg::SAMPLE_W-1){1'b1}}};  // positive rail
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int ch = 0; ch < 2; ch++) begin
            for (int p = 0; p < 4; p++) pair_q[ch][p] <= '0;
            for (int q = 0; q < 2; q++) quad_q[ch][q] <= '0;
            total_q[ch] <= '0;
            dac_q[ch]   <= '0;
         end
         sat_o <= '0;
      end else begin
         for (int ch = 0; ch < 2; ch++) begin
            for (int p = 0; p < 4; p++) pair_q[ch][p] <= leaf[ch][2*p] + leaf[ch][2*p+1];
            for (int q = 0; q < 2; q++) quad_q[ch][q] <= pair_q[ch][2*q] + pair_q[ch][2*q+1];
            total_q[ch] <= quad_q[ch][0] + quad_q[ch][1];
            dac_q[ch]   <= clamp[ch];
         end
         sat_o <= ovf;  // flags line up with the dac words
      end
   end

   assign dac_a_o = dac_q[0];
   assign dac_b_o = dac_q[1];

   // a raised flag means the dac sits on a rail
   for (genvar ch = 0; ch < 2; ch++) begin : g_chk
      a_sat_rail: assert property (@(posedge clk_i) disable iff (!rstn_i)
         sat_o[ch] |-> (dac_q[ch] == {1'b0, {(dsp_pkg::SAMPLE_W-1){1'b1}}} ||
                        dac_q[ch] == {1'b1, {(dsp_pkg::SAMPLE_W-1){1'b0}}}));
   end

endmodule

/* dsp_top.sv */
`timescale 1ns/1ps

module dsp_top (
   input  logic                       clk_i,
   input  logic                       rstn_i,
   input  dsp_pkg::sample_t           adc_a_i,
   input  dsp_pkg::sample_t           adc_b_i,
   input  dsp_pkg::sample_t           asg1_i,
   input  dsp_pkg::sample_t           asg2_i,
   input  logic [bus_pkg::ADDR_W-1:0] sys_addr_i,
   input  logic [bus_pkg::DATA_W-1:0] sys_wdata_i,
   input  logic                       sys_wen_i,
   input  logic                       sys_ren_i,
   output dsp_pkg::sample_t           dac_a_o,
   output dsp_pkg::sample_t           dac_b_o,
   output dsp_pkg::sample_t           scope1_o,
   output dsp_pkg::sample_t           scope2_o,
   output dsp_pkg::sample_t           pwm0_o,
   output dsp_pkg::sample_t           pwm1_o,
   output logic [bus_pkg::DATA_W-1:0] sys_rdata_o,
   output logic                       sys_ack_o
);

   dsp_pkg::sample_t            sources  [dsp_pkg::N_SOURCES];
   dsp_pkg::sample_t            sinks    [dsp_pkg::N_SINKS];
   dsp_pkg::sample_t            direct   [dsp_pkg::N_DIRECT];
   dsp_pkg::sample_t            slot_out [dsp_pkg::N_SLOTS];
   dsp_pkg::src_e               sink_sel [dsp_pkg::N_SINKS];
   dsp_pkg::out_sel_e           out_sel  [dsp_pkg::N_DIRECT];
   logic [dsp_pkg::N_SLOTS-1:0] sync;
   logic [1:0]                  dac_sat;

   slot_bus_if slot_bus [dsp_pkg::N_SLOTS] ();

   // source vector: slots, asg, adc, dac feedback
   for (genvar k = 0; k < dsp_pkg::N_SLOTS; k++) begin : g_src
      assign sources[k] = slot_out[k];
      assign direct[k]  = slot_out[k];  // slot direct output is its dat_o
   end
   assign sources[dsp_pkg::SRC_ASG1] = asg1_i;
   assign sources[dsp_pkg::SRC_ASG2] = asg2_i;
   assign sources[dsp_pkg::SRC_ADC1] = adc_a_i;
   assign sources[dsp_pkg::SRC_ADC2] = adc_b_i;
   assign sources[dsp_pkg::SRC_DAC1] = dac_a_o;  // registered, no comb loop
   assign sources[dsp_pkg::SRC_DAC2] = dac_b_o;
   assign direct[dsp_pkg::N_SLOTS]   = asg1_i;
   assign direct[dsp_pkg::N_SLOTS+1] = asg2_i;

   dsp_regs i_regs (
      .clk_i, .rstn_i, .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
      .sources_i  (sources),
      .dac_sat_i  (dac_sat),
      .sys_rdata_o, .sys_ack_o,
      .sink_sel_o (sink_sel),
      .out_sel_o  (out_sel),
      .sync_o     (sync),
      .slot_bus   (slot_bus)
   );

   signal_router i_router (.sources_i(sources), .sink_sel_i(sink_sel), .sinks_o(sinks));

   for (genvar k = 0; k < dsp_pkg::N_SLOTS; k++) begin : g_slot
      gain_slot i_slot (
         .clk_i, .rstn_i,
         .enable_i (sync[k]),  // sync bit pauses the slot
         .dat_i    (sinks[k]),
         .dat_o    (slot_out[k]),
         .bus      (slot_bus[k])
      );
   end

   dac_summer i_summer (
      .clk_i, .rstn_i, .direct_i(direct), .out_sel_i(out_sel),
      .dac_a_o, .dac_b_o, .sat_o(dac_sat)
   );

   assign scope1_o = sinks[dsp_pkg::SNK_SCOPE1];
   assign scope2_o = sinks[dsp_pkg::SNK_SCOPE2];
   assign pwm0_o   = sinks[dsp_pkg::SNK_PWM0];
   assign pwm1_o   = sinks[dsp_pkg::SNK_PWM1];

endmodule

/* tb_dsp.sv */
`timescale 1ns/1ps

module tb_dsp;

   localparam int ACK_LIMIT = 20;     // cycles a bus access may take
   localparam int S_MAX     = 8191;   // 14-bit rails
   localparam int S_MIN     = -8192;

   logic             clk_i;
   logic             rstn_i;
   dsp_pkg::sample_t adc_a_i, adc_b_i, asg1_i, asg2_i;
   logic [31:0]      sys_addr_i, sys_wdata_i;
   logic             sys_wen_i, sys_ren_i;
   dsp_pkg::sample_t dac_a_o, dac_b_o, scope1_o, scope2_o, pwm0_o, pwm1_o;
   logic [31:0]      sys_rdata_o;
   logic             sys_ack_o;
   logic [31:0]      rng_state;

   dsp_top i_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;  // 8 ns
   end

   task automatic fail_run();
      $display("Testbench failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic mismatch(input string msg);
      $display("** Error @ %0t ns: %s", $time, msg);
      fail_run();
   endtask

   // ack drops after one cycle unless the next access starts in it
   a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_ack_o && !sys_wen_i && !sys_ren_i |=> !sys_ack_o)
      else mismatch("bus ack held with no new access");

   task automatic next_cycle();
      @(posedge clk_i);
      #1;  // drive point
   endtask

   function automatic logic [31:0] next_random();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic dsp_pkg::sample_t random_sample();
      logic [31:0] r;
      r = next_random();
      return r[13:0];  // full signed range
   endfunction

   function automatic int clamp_sample(int v);
      if (v > S_MAX) return S_MAX;
      if (v < S_MIN) return S_MIN;
      return v;
   endfunction

   // product, arithmetic shift by 10, clamp
   function automatic int apply_gain(int x, int g);
      int p;
      p = x * g;
      p = p >>> 10;
      return clamp_sample(p);
   endfunction

   // value the crossbar should pass for a code
   function automatic int source_value(int code);
      case (code)
         4: return int'(asg1_i);
         5: return int'(asg2_i);
         6: return int'(adc_a_i);
         7: return int'(adc_b_i);
         default: return 0;  // dacs still off here, none and unused codes
      endcase
   endfunction

   function automatic logic [31:0] reg_addr(int idx, int ofs);
      return (32'(idx) << 16) | (32'(ofs) & 32'hFFFF);
   endfunction

   // called at a drive point, returns at the drive point after ack
   task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output int cycles);
      sys_addr_i  = addr;
      sys_wdata_i = wdata;
      sys_wen_i   = wr;
      sys_ren_i   = !wr;
      next_cycle();
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      cycles    = 1;
      while (!sys_ack_o) begin
         if (cycles >= ACK_LIMIT) begin
            $display("no bus acknowledge within %0d cycles at address %h", ACK_LIMIT, addr);
            fail_run();
         end
         next_cycle();
         cycles++;
      end
      rdata = sys_rdata_o;
   endtask

   task automatic write_reg(input int idx, input int ofs, input logic [31:0] data);
      logic [31:0] unused_rd;
      int          unused_cyc;
      bus_access(1'b1, reg_addr(idx, ofs), data, unused_rd, unused_cyc);
   endtask

   task automatic read_reg(input int idx, input int ofs, output logic [31:0] data,
                           output int cycles);
      bus_access(1'b0, reg_addr(idx, ofs), 32'h0, data, cycles);
   endtask

   initial begin
      int          cyc;
      logic [31:0] rd;
      logic [31:0] exp;
      logic [31:0] r;
      int          g;
      int          v;
      int          frozen;
      int          sel [4];
      int          got [4];
      int          h1 [16];
      int          h2 [16];
      int          gains [3];

      rng_state = 32'd30;
      gains     = '{700, -20000, 32767};  // last two hit the rails
      rstn_i    = 1'b0;
      adc_a_i   = '0;
      adc_b_i   = '0;
      asg1_i    = '0;
      asg2_i    = '0;
      sys_addr_i  = '0;
      sys_wdata_i = '0;
      sys_wen_i   = 1'b0;
      sys_ren_i   = 1'b0;
      repeat (3) @(posedge clk_i);
      #1 rstn_i = 1'b1;

      // defaults after reset
      @(negedge clk_i);
      assert (pwm0_o == 0 && pwm1_o == 0 && dac_a_o == 0 && dac_b_o == 0)
         else mismatch("pwm or dac output not zero after reset");
      next_cycle();
      for (int k = 0; k < 8; k++) begin
         read_reg(k, 'h00, rd, cyc);
         exp = (k < 5) ? 32'd6 : (k == 5) ? 32'd7 : 32'd15;  // adc1, adc2, none
         assert (rd == exp) else mismatch($sformatf("insel %0d is %h, expected %h", k, rd, exp));
      end
      for (int k = 0; k < 6; k++) begin
         read_reg(k, 'h04, rd, cyc);
         assert (rd == 0) else mismatch($sformatf("outsel %0d is %h after reset", k, rd));
      end
      read_reg(0, 'h0C, rd, cyc);
      assert (rd == 32'hF) else mismatch($sformatf("sync is %h after reset", rd));

      // ack latency and readback
      read_reg(4, 'h00, rd, cyc);
      assert (cyc == 1) else mismatch($sformatf("local read acked after %0d cycles", cyc));
      write_reg(1, 'h20, 32'hABCD_1234);
      read_reg(1, 'h20, rd, cyc);
      assert (cyc == 2) else mismatch($sformatf("gain read acked after %0d cycles", cyc));
      assert (rd == 32'h1234) else mismatch($sformatf("gain reads %h, expected 1234", rd));
      write_reg(2, 'h04, 32'd2);
      read_reg(2, 'h04, rd, cyc);
      assert (rd == 2) else mismatch($sformatf("outsel 2 reads %h, expected 2", rd));
      write_reg(2, 'h04, 32'd0);
      read_reg(9, 'h20, rd, cyc);  // no such slot
      assert (cyc == 1 && rd == 0)
         else mismatch($sformatf("missing slot gave %h after %0d cycles", rd, cyc));

      // crossbar to scope and pwm sinks, same cycle
      for (int it = 0; it < 6; it++) begin
         for (int s = 0; s < 4; s++) begin
            r      = next_random() % 8;
            sel[s] = (r < 6) ? 4 + int'(r) : (r == 6) ? 15 : 12;
            write_reg(4 + s, 'h00, 32'(sel[s]));
         end
         adc_a_i = random_sample();
         adc_b_i = random_sample();
         asg1_i  = random_sample();
         asg2_i  = random_sample();
         @(negedge clk_i);
         got = '{int'(scope1_o), int'(scope2_o), int'(pwm0_o), int'(pwm1_o)};
         for (int s = 0; s < 4; s++) begin
            assert (got[s] == source_value(sel[s]))
               else mismatch($sformatf("sink %0d with code %0d is %0d, expected %0d",
                                       4 + s, sel[s], got[s], source_value(sel[s])));
         end
         next_cycle();
      end

      // slot 0 on adc1, shown on scope1
      write_reg(0, 'h00, 32'd6);
      write_reg(4, 'h00, 32'd0);
      foreach (gains[n]) begin
         g = gains[n];
         write_reg(0, 'h20, 32'(g));
         for (int i = 0; i < 12; i++) begin
            adc_a_i = random_sample();
            h1[i]   = int'(adc_a_i);
            if (i >= 2) begin  // two-stage slot
               @(negedge clk_i);
               assert (int'(scope1_o) == apply_gain(h1[i-2], g))
                  else mismatch($sformatf("slot out %0d, expected %0d for gain %0d",
                                          scope1_o, apply_gain(h1[i-2], g), g));
            end
            next_cycle();
         end
      end

      // pause slot 0, output stays put
      g = 700;
      write_reg(0, 'h20, 32'(g));
      adc_a_i = random_sample();
      v       = int'(adc_a_i);
      next_cycle();
      write_reg(0, 'h0C, 32'hE);
      frozen = apply_gain(v, g);
      for (int i = 0; i < 8; i++) begin
         adc_a_i = random_sample();
         @(negedge clk_i);
         assert (int'(scope1_o) == frozen)
            else mismatch($sformatf("paused slot out %0d, expected %0d", scope1_o, frozen));
         next_cycle();
      end
      write_reg(0, 'h0C, 32'hF);
      for (int i = 0; i < 10; i++) begin
         adc_a_i = random_sample();
         h1[i]   = int'(adc_a_i);
         if (i >= 2) begin
            @(negedge clk_i);
            assert (int'(scope1_o) == apply_gain(h1[i-2], g))
               else mismatch($sformatf("resumed slot out %0d, expected %0d",
                                       scope1_o, apply_gain(h1[i-2], g)));
         end
         next_cycle();
      end

      // asg1 to dac a, asg2 to both
      write_reg(4, 'h04, 32'd1);
      write_reg(5, 'h04, 32'd3);
      for (int i = 0; i < 16; i++) begin
         asg1_i = random_sample();
         asg2_i = random_sample();
         h1[i]  = int'(asg1_i);
         h2[i]  = int'(asg2_i);
         if (i >= 4) begin  // pairs, quads, total, clamp
            @(negedge clk_i);
            assert (int'(dac_a_o) == clamp_sample(h1[i-4] + h2[i-4]))
               else mismatch($sformatf("dac a %0d, expected %0d",
                                       dac_a_o, clamp_sample(h1[i-4] + h2[i-4])));
            assert (int'(dac_b_o) == h2[i-4])
               else mismatch($sformatf("dac b %0d, expected %0d", dac_b_o, h2[i-4]));
         end
         next_cycle();
      end
      for (int n = 0; n < 3; n++) begin
         v      = (n == 0) ? 8000 : (n == 1) ? -8000 : 100;
         asg1_i = dsp_pkg::sample_t'(v);
         asg2_i = dsp_pkg::sample_t'(v);
         repeat (5) next_cycle();  // past the 4-cycle tree
         read_reg(0, 'h08, rd, cyc);
         exp = (n < 2) ? 32'd1 : 32'd0;  // only channel a overflows
         assert (rd == exp) else mismatch($sformatf("sat flags %h, expected %h", rd, exp));
         assert (int'(dac_a_o) == clamp_sample(2 * v) && int'(dac_b_o) == v)
            else mismatch($sformatf("dac pair %0d/%0d for asg %0d", dac_a_o, dac_b_o, v));
      end

      $display("Testbench passed");
      $finish;
   end

endmodule

/* src.f */
dsp_pkg.sv
bus_pkg.sv
slot_bus_if.sv
dsp_regs.sv
signal_router.sv
gain_slot.sv
dac_summer.sv
dsp_top.sv
tb_dsp.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dsp
VFLAGS    ?= -j 0
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP VFLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f src.f
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
